/* rtl/ddr_phy_pkg.sv */
// widths and bus types of the DDR2 read data path at the PHY side
package ddr_phy_pkg;

  // number of DQS byte groups on the memory interface
  localparam int dqs_width = 9;

  // DQ bits captured by each DQS strobe
  localparam int dq_per_dqs = 8;

  // full DQ bus, which carries one 72-bit codeword per clock edge
  localparam int dq_width = dqs_width * dq_per_dqs;

  // data of one edge (rise or fall) across all byte groups
  typedef logic [dq_width-1:0] dq_bus_t;

  // one bit per byte group, used for read enables and skew selects
  typedef logic [dqs_width-1:0] dqs_vec_t;

endpackage

/* rtl/ecc_pkg.sv */
// SECDED (72,64) code definitions shared by the decoder and the ECC stage
package ecc_pkg;

  localparam int ecc_data_width = 64;

  // seven Hamming check bits plus one overall parity bit
  localparam int ecc_check_width = 8;

  localparam int ecc_syn_width = ecc_check_width - 1;

  localparam int ecc_code_width = ecc_data_width + ecc_check_width;

  // cycles from aligned data in to corrected data out of rd_ecc_stage
  localparam int ecc_latency = 3;

  typedef logic [ecc_data_width-1:0] app_word_t;
  typedef logic [ecc_syn_width-1:0] syndrome_t;

  // bit 0 is a corrected single error, bit 1 an uncorrectable double error
  typedef logic [1:0] ecc_err_t;

  // codeword position (1 to 71) of a bus bit
  // data bits fill the non power of two positions in order, check bit k sits at 2**k
  function automatic syndrome_t code_pos(input int bit_idx);
    syndrome_t pos;
    int cnt;
    pos = '0;
    cnt = 0;
    if (bit_idx >= ecc_data_width) begin
      pos = syndrome_t'(1 << (bit_idx - ecc_data_width));
    end else begin
      for (int p = 3; p < ecc_code_width; p++) begin
        if ((p & (p - 1)) != 0) begin
          if (cnt == bit_idx) begin
            pos = syndrome_t'(p);
          end
          cnt++;
        end
      end
    end
    return pos;
  endfunction

endpackage

/* rtl/rd_skew_align.sv */
`timescale 1ns/1ps

module rd_skew_align (
  input  logic                 clk0,
  input  logic                 rst0,
  input  ddr_phy_pkg::dq_bus_t  rd_data_rise_i,
  input  ddr_phy_pkg::dq_bus_t  rd_data_fall_i,
  input  ddr_phy_pkg::dqs_vec_t ctrl_rden_i,
  input  ddr_phy_pkg::dqs_vec_t ctrl_rden_sel_i,
  output ddr_phy_pkg::dq_bus_t  aln_rise_o,
  output ddr_phy_pkg::dq_bus_t  aln_fall_o,
  output logic                 aln_valid_o
);

  import ddr_phy_pkg::*;

  // first capture of the pin data and a second copy one clock older
  dq_bus_t  rise_r;
  dq_bus_t  fall_r;
  dq_bus_t  rise_rr;
  dq_bus_t  fall_rr;
  dq_bus_t  rise_sel;
  dq_bus_t  fall_sel;
  dqs_vec_t rden_sel_r;
  logic     rden0_r;
  logic     rden0_rr;
  logic     rden_aln;

  always_ff @(posedge clk0) begin
    rise_r     <= rd_data_rise_i;
    fall_r     <= rd_data_fall_i;
    rise_rr    <= rise_r;
    fall_rr    <= fall_r;
    rden_sel_r <= ctrl_rden_sel_i;
  end

  // the read enable pipeline is control state and starts empty
  always_ff @(posedge clk0) begin
    if (rst0) begin
      rden0_r  <= 1'b0;
      rden0_rr <= 1'b0;
    end else begin
      rden0_r  <= ctrl_rden_i[0];
      rden0_rr <= rden0_r;
    end
  end

  // a group with select 1 arrived late and takes the fresh copy,
  // a group with select 0 arrived early and takes the older one
  genvar g;
  generate
    for (g = 0; g < dqs_width; g++) begin : gen_byte
      assign rise_sel[g*dq_per_dqs +: dq_per_dqs] = rden_sel_r[g] ?
                                                     rise_r[g*dq_per_dqs +: dq_per_dqs] :
                                                     rise_rr[g*dq_per_dqs +: dq_per_dqs];
      assign fall_sel[g*dq_per_dqs +: dq_per_dqs] = rden_sel_r[g] ?
                                                     fall_r[g*dq_per_dqs +: dq_per_dqs] :
                                                     fall_rr[g*dq_per_dqs +: dq_per_dqs];
    end
  endgenerate

  // the valid tracks group 0, so it sees the same skew choice as byte 0
  assign rden_aln = rden_sel_r[0] ? rden0_r : rden0_rr;

  always_ff @(posedge clk0) begin
    aln_rise_o <= rise_sel;
    aln_fall_o <= fall_sel;
  end

  always_ff @(posedge clk0) begin
    if (rst0) begin
      aln_valid_o <= 1'b0;
    end else begin
      aln_valid_o <= rden_aln;
    end
  end

endmodule

/* rtl/secded_decode.sv */
`timescale 1ns/1ps

module secded_decode (
  input  logic                 clk0,
  input  ddr_phy_pkg::dq_bus_t code_i,
  output ecc_pkg::app_word_t   data_o,
  output logic                 single_o,
  output logic                 double_o
);

  import ddr_phy_pkg::*;
  import ecc_pkg::*;

  // stage 1 results
  syndrome_t syn_calc;
  logic      par_err;
  dq_bus_t   code_r;
  syndrome_t syn_r;
  logic      par_r;

  // stage 2 results
  app_word_t data_fix;
  logic      single_err;
  logic      double_err;

  // the syndrome is the XOR of the positions of all set bits except the
  // overall parity, which is zero for a clean codeword
  always_comb begin
    syn_calc = '0;
    for (int b = 0; b < dq_width - 1; b++) begin
      if (code_i[b]) begin
        syn_calc = syn_calc ^ code_pos(b);
      end
    end
  end

  // even parity over all 72 bits holds for a clean word
  assign par_err = ^code_i;

  always_ff @(posedge clk0) begin
    code_r <= code_i;
    syn_r  <= syn_calc;
    par_r  <= par_err;
  end

  // a bad overall parity means an odd number of flips, taken as one error
  // at the position that the syndrome names
  // a syndrome that points at a check bit or at zero leaves the data alone
  always_comb begin
    data_fix = code_r[ecc_data_width-1:0];
    for (int b = 0; b < ecc_data_width; b++) begin
      if (par_r && (syn_r == code_pos(b))) begin
        data_fix[b] = ~code_r[b];
      end
    end
  end

  assign single_err = par_r;

  // good parity with a nonzero syndrome can only come from two flips
  assign double_err = ~par_r & (|syn_r);

  always_ff @(posedge clk0) begin
    data_o   <= data_fix;
    single_o <= single_err;
    double_o <= double_err;
  end

endmodule

/* rtl/rd_ecc_stage.sv */
`timescale 1ns/1ps

module rd_ecc_stage (
  input  logic                 clk0,
  input  logic                 rst0,
  input  ddr_phy_pkg::dq_bus_t aln_rise_i,
  input  ddr_phy_pkg::dq_bus_t aln_fall_i,
  input  logic                 aln_valid_i,
  output ecc_pkg::app_word_t   rd_data_rise_o,
  output ecc_pkg::app_word_t   rd_data_fall_o,
  output logic                 rd_data_valid_o,
  output ecc_pkg::ecc_err_t    rd_ecc_error_o
);

  import ddr_phy_pkg::*;
  import ecc_pkg::*;

  dq_bus_t                rise_r;
  dq_bus_t                fall_r;
  logic [ecc_latency-1:0] vld_pipe;
  logic                   sgl_rise;
  logic                   dbl_rise;
  logic                   sgl_fall;
  logic                   dbl_fall;

  // input register in front of the decoders
  always_ff @(posedge clk0) begin
    rise_r <= aln_rise_i;
    fall_r <= aln_fall_i;
  end

  // the valid walks beside the data through the input register and
  // both decoder stages
  always_ff @(posedge clk0) begin
    if (rst0) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[ecc_latency-2:0], aln_valid_i};
    end
  end

  assign rd_data_valid_o = vld_pipe[ecc_latency-1];

  secded_decode u_dec_rise (
    .clk0     (clk0),
    .code_i   (rise_r),
    .data_o   (rd_data_rise_o),
    .single_o (sgl_rise),
    .double_o (dbl_rise)
  );

  secded_decode u_dec_fall (
    .clk0     (clk0),
    .code_i   (fall_r),
    .data_o   (rd_data_fall_o),
    .single_o (sgl_fall),
    .double_o (dbl_fall)
  );

  // either edge may raise the one status of the whole beat
  // flags between bursts come from stale codewords and are masked
  assign rd_ecc_error_o[0] = (sgl_rise | sgl_fall) & rd_data_valid_o;
  assign rd_ecc_error_o[1] = (dbl_rise | dbl_fall) & rd_data_valid_o;

endmodule

/* rtl/ddr_rd_top.sv */
`timescale 1ns/1ps

module ddr_rd_top (
  input  logic                  clk0,
  input  logic                  rst0,
  input  ddr_phy_pkg::dq_bus_t  rd_data_rise_i,
  input  ddr_phy_pkg::dq_bus_t  rd_data_fall_i,
  input  ddr_phy_pkg::dqs_vec_t ctrl_rden_i,
  input  ddr_phy_pkg::dqs_vec_t ctrl_rden_sel_i,
  output ecc_pkg::app_word_t    rd_data_rise_o,
  output ecc_pkg::app_word_t    rd_data_fall_o,
  output logic                  rd_data_valid_o,
  output ecc_pkg::ecc_err_t     rd_ecc_error_o
);

  import ddr_phy_pkg::*;

  // byte-aligned codewords between the deskew and the ECC stage
  dq_bus_t aln_rise;
  dq_bus_t aln_fall;
  logic    aln_valid;

  rd_skew_align u_skew_align (
    .clk0            (clk0),
    .rst0            (rst0),
    .rd_data_rise_i  (rd_data_rise_i),
    .rd_data_fall_i  (rd_data_fall_i),
    .ctrl_rden_i     (ctrl_rden_i),
    .ctrl_rden_sel_i (ctrl_rden_sel_i),
    .aln_rise_o      (aln_rise),
    .aln_fall_o      (aln_fall),
    .aln_valid_o     (aln_valid)
  );

  rd_ecc_stage u_ecc_stage (
    .clk0            (clk0),
    .rst0            (rst0),
    .aln_rise_i      (aln_rise),
    .aln_fall_i      (aln_fall),
    .aln_valid_i     (aln_valid),
    .rd_data_rise_o  (rd_data_rise_o),
    .rd_data_fall_o  (rd_data_fall_o),
    .rd_data_valid_o (rd_data_valid_o),
    .rd_ecc_error_o  (rd_ecc_error_o)
  );

endmodule

/* include/tb_ecc_model.svh */
`ifndef TB_ECC_MODEL_SVH
`define TB_ECC_MODEL_SVH

// reference encoder for the (72,64) extended Hamming code
// bus bits 0 to 63 are data, 64 to 70 check bits c0 to c6, 71 overall parity
function automatic ddr_phy_pkg::dq_bus_t encode_secded(input ecc_pkg::app_word_t data);
  ddr_phy_pkg::dq_bus_t code;
  logic [6:0]           chk;
  int                   d;
  code = '0;
  chk  = '0;
  d    = 0;
  code[63:0] = data;
  // walk the codeword positions and give each data bit the next free slot
  for (int p = 1; p < 72; p++) begin
    if ((p & (p - 1)) != 0) begin
      for (int k = 0; k < 7; k++) begin
        if (p[k]) begin
          chk[k] = chk[k] ^ data[d];
        end
      end
      d++;
    end
  end
  code[70:64] = chk;
  code[71]    = ^code[70:0];
  return code;
endfunction

// invert one bus bit to inject an error
function automatic ddr_phy_pkg::dq_bus_t flip_bit(input ddr_phy_pkg::dq_bus_t code,
                                                  input int idx);
  ddr_phy_pkg::dq_bus_t res;
  res      = code;
  res[idx] = ~res[idx];
  return res;
endfunction

// one step of the 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  logic fb;
  fb = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], fb};
endfunction

`endif

/* tb/tb_ddr_rd_top.sv */
`timescale 1ns/1ps

module tb_ddr_rd_top;

  import ddr_phy_pkg::*;
  import ecc_pkg::*;

  `include "tb_ecc_model.svh"

  localparam int clk_period   = 100;
  localparam int drive_delay  = 10;
  localparam int reset_cycles = 16;
  localparam int max_beats    = 64;

  // six bursts of at most max_beats slots plus their pipeline tails stay far below this
  localparam int cycle_limit  = 2000;

  logic      clk0;
  logic      rst0;
  dq_bus_t   rd_data_rise_i;
  dq_bus_t   rd_data_fall_i;
  dqs_vec_t  ctrl_rden_i;
  dqs_vec_t  ctrl_rden_sel_i;
  app_word_t rd_data_rise_o;
  app_word_t rd_data_fall_o;
  logic      rd_data_valid_o;
  ecc_err_t  rd_ecc_error_o;

  // one burst as seen by the controller with one entry per nominal slot
  dq_bus_t   nom_rise [max_beats];
  dq_bus_t   nom_fall [max_beats];
  logic      nom_en   [max_beats];
  app_word_t exp_rise [max_beats];
  app_word_t exp_fall [max_beats];
  ecc_err_t  exp_err  [max_beats];
  int        nom_len;

  logic [15:0] lfsr_q;
  int          value_errors;
  int          valid_errors;
  int          cycles;

  ddr_rd_top UUT (
    .clk0            (clk0),
    .rst0            (rst0),
    .rd_data_rise_i  (rd_data_rise_i),
    .rd_data_fall_i  (rd_data_fall_i),
    .ctrl_rden_i     (ctrl_rden_i),
    .ctrl_rden_sel_i (ctrl_rden_sel_i),
    .rd_data_rise_o  (rd_data_rise_o),
    .rd_data_fall_o  (rd_data_fall_o),
    .rd_data_valid_o (rd_data_valid_o),
    .rd_ecc_error_o  (rd_ecc_error_o)
  );

  initial begin
    clk0 = 1'b0;
    forever #(clk_period / 2) clk0 = ~clk0;
  end

  always @(posedge clk0) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run went past the cycle limit without finishing");
      $display("tests failed");
      $finish;
    end
  end

  // steps the LFSR once for every bit taken
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r      = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic int random_index(input int range);
    return int'(lfsr_bits(7)) % range;
  endfunction

  task automatic add_beat(input dq_bus_t rise, input dq_bus_t fall, input app_word_t er,
                          input app_word_t ef, input ecc_err_t ee);
    nom_rise[nom_len] = rise;
    nom_fall[nom_len] = fall;
    nom_en[nom_len]   = 1'b1;
    exp_rise[nom_len] = er;
    exp_fall[nom_len] = ef;
    exp_err[nom_len]  = ee;
    nom_len++;
  endtask

  task automatic add_clean_beat();
    app_word_t dr;
    app_word_t df;
    dr = lfsr_bits(64);
    df = lfsr_bits(64);
    add_beat(encode_secded(dr), encode_secded(df), dr, df, 2'b00);
  endtask

  // the pins carry a double-error word while the enable is low
  task automatic add_gap();
    dq_bus_t noise;
    noise             = flip_bit(flip_bit(encode_secded(lfsr_bits(64)), 5), 66);
    nom_rise[nom_len] = noise;
    nom_fall[nom_len] = noise;
    nom_en[nom_len]   = 1'b0;
    exp_rise[nom_len] = '0;
    exp_fall[nom_len] = '0;
    exp_err[nom_len]  = 2'b00;
    nom_len++;
  endtask

  // groups with select 1 reach the pins one cycle after the others
  task automatic drive_pins(input int slot, input dqs_vec_t sel);
    int src;
    for (int g = 0; g < dqs_width; g++) begin
      src = sel[g] ? slot - 1 : slot;
      if (src >= 0 && src < nom_len) begin
        rd_data_rise_i[g*dq_per_dqs +: dq_per_dqs] = nom_rise[src][g*dq_per_dqs +: dq_per_dqs];
        rd_data_fall_i[g*dq_per_dqs +: dq_per_dqs] = nom_fall[src][g*dq_per_dqs +: dq_per_dqs];
        ctrl_rden_i[g] = nom_en[src];
      end else begin
        rd_data_rise_i[g*dq_per_dqs +: dq_per_dqs] = '0;
        rd_data_fall_i[g*dq_per_dqs +: dq_per_dqs] = '0;
        ctrl_rden_i[g] = 1'b0;
      end
    end
  endtask

  task automatic check_slot(input int slot);
    logic exp_v;
    exp_v = 1'b0;
    if (slot >= 0 && slot < nom_len) begin
      exp_v = nom_en[slot];
    end
    assert (rd_data_valid_o == exp_v) else begin
      if (exp_v) begin
        $display("missing valid for burst slot %0d", slot);
      end else begin
        $display("valid seen where no beat was sent, burst slot %0d", slot);
      end
      valid_errors++;
    end
    if (!rd_data_valid_o) begin
      assert (rd_ecc_error_o == 2'b00) else begin
        $display("Fail rd_ecc_error_o outside valid: got %h expected %h", rd_ecc_error_o, 2'b00);
        value_errors++;
      end
    end else if (exp_v) begin
      assert (rd_data_rise_o == exp_rise[slot]) else begin
        $display("Fail rd_data_rise_o slot %0d: got %h expected %h",
                 slot, rd_data_rise_o, exp_rise[slot]);
        value_errors++;
      end
      assert (rd_data_fall_o == exp_fall[slot]) else begin
        $display("Fail rd_data_fall_o slot %0d: got %h expected %h",
                 slot, rd_data_fall_o, exp_fall[slot]);
        value_errors++;
      end
      assert (rd_ecc_error_o == exp_err[slot]) else begin
        $display("Fail rd_ecc_error_o slot %0d: got %h expected %h",
                 slot, rd_ecc_error_o, exp_err[slot]);
        value_errors++;
      end
    end
  endtask

  // a driven slot is sampled one edge later, then the late group 0 adds its skew
  task automatic run_burst(input dqs_vec_t sel, input int exp_lat);
    int out_offset;
    int first_en;
    int first_vld;
    out_offset = 1 + int'(sel[0]) + exp_lat;
    first_en   = -1;
    first_vld  = -1;
    @(posedge clk0);
    #drive_delay;
    ctrl_rden_sel_i = sel;
    drive_pins(-2, sel);
    repeat (2) @(posedge clk0);
    for (int i = 0; i < nom_len + out_offset + 3; i++) begin
      @(posedge clk0);
      #drive_delay;
      check_slot(i - out_offset);
      if (rd_data_valid_o && first_vld < 0) begin
        first_vld = i;
      end
      drive_pins(i, sel);
      if (ctrl_rden_i[0] && first_en < 0) begin
        first_en = i;
      end
    end
    if (first_vld < 0) begin
      $display("no valid came back for the burst");
      valid_errors++;
    end else begin
      assert (first_vld - (first_en + 1) == exp_lat) else begin
        $display("Fail rd_data_valid_o latency: got %h expected %h",
                 first_vld - (first_en + 1), exp_lat);
        value_errors++;
      end
    end
  endtask

  task automatic reset_and_single_beat();
    $display("test 1: reset state and one beat");
    assert (rd_data_valid_o == 1'b0 && rd_ecc_error_o == 2'b00) else begin
      $display("Fail rd_data_valid_o/rd_ecc_error_o after reset: got %h/%h expected 0/0",
               rd_data_valid_o, rd_ecc_error_o);
      value_errors++;
    end
    nom_len = 0;
    add_clean_beat();
    run_burst(9'h1ff, 4);
  endtask

  task automatic mixed_skew_bursts();
    $display("test 2: mixed skew bursts");
    nom_len = 0;
    repeat (16) add_clean_beat();
    run_burst(9'h155, 4);
    nom_len = 0;
    repeat (16) add_clean_beat();
    run_burst(9'h154, 5);
  endtask

  task automatic single_error_burst();
    app_word_t dr;
    app_word_t df;
    int        pos;
    $display("test 3: single bit errors");
    nom_len = 0;
    for (int b = 0; b < 24; b++) begin
      dr = lfsr_bits(64);
      df = lfsr_bits(64);
      // the first beats hit the parity bit, both ends of the check field and a data bit
      case (b)
        0:       pos = 71;
        1:       pos = 64;
        2:       pos = 70;
        3:       pos = 0;
        default: pos = random_index(72);
      endcase
      if (lfsr_bits(1) == 64'd1) begin
        add_beat(flip_bit(encode_secded(dr), pos), encode_secded(df), dr, df, 2'b01);
      end else begin
        add_beat(encode_secded(dr), flip_bit(encode_secded(df), pos), dr, df, 2'b01);
      end
    end
    run_burst(9'h155, 4);
  endtask

  task automatic double_error_burst();
    app_word_t dr;
    app_word_t df;
    dq_bus_t   bad;
    int        pa;
    int        pb;
    $display("test 4: double bit errors");
    nom_len = 0;
    for (int b = 0; b < 12; b++) begin
      if (b % 3 == 1) begin
        dr  = lfsr_bits(64);
        df  = lfsr_bits(64);
        pa  = random_index(72);
        pb  = (pa + 1 + random_index(71)) % 72;
        if (lfsr_bits(1) == 64'd1) begin
          bad = flip_bit(flip_bit(encode_secded(dr), pa), pb);
          add_beat(bad, encode_secded(df), bad[63:0], df, 2'b10);
        end else begin
          bad = flip_bit(flip_bit(encode_secded(df), pa), pb);
          add_beat(encode_secded(dr), bad, dr, bad[63:0], 2'b10);
        end
      end else begin
        add_clean_beat();
      end
    end
    run_burst(9'h0aa, 5);
  endtask

  task automatic gapped_enable_burst();
    logic [19:0] pattern;
    $display("test 5: read enable with gaps");
    pattern = 20'b1110_1101_0001_1100_1011;
    nom_len = 0;
    for (int s = 0; s < 20; s++) begin
      if (pattern[s]) begin
        add_clean_beat();
      end else begin
        add_gap();
      end
    end
    run_burst(9'h133, 4);
  endtask

  initial begin
    rst0            = 1'b1;
    rd_data_rise_i  = '0;
    rd_data_fall_i  = '0;
    ctrl_rden_i     = '0;
    ctrl_rden_sel_i = '1;
    lfsr_q          = 16'd18970;
    value_errors    = 0;
    valid_errors    = 0;
    cycles          = 0;
    nom_len         = 0;
    repeat (reset_cycles) @(posedge clk0);
    #drive_delay;
    rst0 = 1'b0;

    reset_and_single_beat();
    mixed_skew_bursts();
    single_error_burst();
    double_error_burst();
    gapped_enable_burst();

    $display("errors: %0d value, %0d valid, %0d total",
             value_errors, valid_errors, value_errors + valid_errors);
    if (value_errors + valid_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
rtl/ddr_phy_pkg.sv
rtl/ecc_pkg.sv
rtl/rd_skew_align.sv
rtl/secded_decode.sv
rtl/rd_ecc_stage.sv
rtl/ddr_rd_top.sv
tb/tb_ddr_rd_top.sv

/* Makefile */
# Verilator build and run of the DDR2 read data path testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f \
		--top-module tb_ddr_rd_top -Mdir obj_dir -o sim_ddr_rd
	./obj_dir/sim_ddr_rd | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
